/* src/wfm_settings.svh */
// Waveform engine settings for drive frame counts and state field widths
`ifndef WFM_SETTINGS_SVH
`define WFM_SETTINGS_SVH

// Fast mono drive lengths, in frames
`define WFM_FASTM_B2W_FRAMES 9
`define WFM_FASTM_W2B_FRAMES 9

// Fast grey hold off before the grey pulse
`define WFM_HOLDOFF_FRAMES 10

// Fast grey pulse lengths
`define WFM_B2G_FRAMES 1
`define WFM_W2G_FRAMES 1

// Undriven frames that close the grey stage
`define WFM_SETTLE_FRAMES 5

// Per-pixel frame counter and global frame counter widths
`define WFM_CNT_W 6
`define WFM_OPCNT_W 7

`endif

/* src/wfm_pkg.sv */
// Waveform engine types for the pixel state word, global operation and drive codes
`include "wfm_settings.svh"

package wfm_pkg;

    // Upper nibble of the stored state
    typedef enum logic [3:0] {
        MODE_FAST_MONO = 4'd8,
        MODE_FAST_GREY = 4'd11
    } pixel_mode_t;

    // Fast grey progress, reserved area in mono
    typedef enum logic [1:0] {
        STAGE_DONE = 2'd0,
        STAGE_MONO = 2'd1,
        STAGE_HOLD = 2'd2,
        STAGE_GREY = 2'd3
    } grey_stage_t;

    // Panel drive code
    typedef enum logic [1:0] {
        DRIVE_NONE  = 2'd0,
        DRIVE_BLACK = 2'd1,
        DRIVE_WHITE = 2'd2
    } drive_t;

    typedef enum logic [7:0] {
        OP_NONE    = 8'd0,
        OP_REDRAW  = 8'd1,
        OP_SETMODE = 8'd2
    } op_cmd_t;

    // Set-mode parameter, other codes fall back to mono
    typedef enum logic [7:0] {
        SET_FAST_MONO = 8'd0,
        SET_FAST_GREY = 8'd1
    } setmode_t;

    // Frame timer command from the stage logic
    typedef enum logic [2:0] {
        TMR_HOLD,
        TMR_DEC,
        TMR_LOAD_MONO,
        TMR_RELOAD_MONO,
        TMR_LOAD_HOLDOFF,
        TMR_LOAD_GREY,
        TMR_CLEAR
    } timer_cmd_t;

    // 16-bit VRAM word
    typedef struct packed {
        pixel_mode_t             mode;
        grey_stage_t             stage;
        logic [`WFM_CNT_W-1:0]   count;
        logic [1:0]              dfrc;
        logic [1:0]              prev;
    } pixel_state_t;

    // Global operation, shared by every pixel of a frame
    typedef struct packed {
        logic                    valid;
        op_cmd_t                 cmd;
        setmode_t                param;
        logic [`WFM_OPCNT_W-1:0] framecnt;
        logic                    init;
    } op_t;

endpackage

/* src/pixel_source_select.sv */
// Pixel source select, decodes the global operation and picks the effective input value
`timescale 1ns/1ns

module pixel_source_select (
    input  logic [3:0]   pix_in,
    input  wfm_pkg::op_t op,
    output logic [3:0]   vin,
    output logic         force_clear,
    output logic         set_mode_apply
);
    import wfm_pkg::*;

    logic       redraw_en;
    logic       setmode_en;
    logic       op_cnt_zero;
    logic [3:0] clear_color;

    // Command strobes only count with a valid operation
    assign redraw_en  = op.valid && (op.cmd == OP_REDRAW);
    assign setmode_en = op.valid && (op.cmd == OP_SETMODE);

    // Global counter at zero marks the first frame of the operation
    assign op_cnt_zero = (op.framecnt == '0);

    // Mode switch lands on the first frame
    assign set_mode_apply = setmode_en && op_cnt_zero;

    // Later set-mode frames wipe the panel like a redraw
    assign force_clear = redraw_en || (setmode_en && !op_cnt_zero);

    // Clear colour alternates with the global counter
    // Black when bits 4:3 are set or bit 5 is set, white otherwise
    always_comb begin
        if (op.framecnt[4:3] == 2'b11) begin
            clear_color = 4'h0;
        end else if (op.framecnt[5]) begin
            clear_color = 4'h0;
        end else begin
            clear_color = 4'hF;
        end
    end

    // Effective value seen by the stage logic
    assign vin = force_clear ? clear_color : pix_in;

endmodule

/* src/frame_timer.sv */
// Frame timer, next value of the per-pixel frame counter and the dynamic frame-rate cap
`timescale 1ns/1ns
`include "wfm_settings.svh"

module frame_timer (
    input  logic [`WFM_CNT_W-1:0] count,
    input  logic [1:0]            dfrc,
    input  logic [1:0]            csr_dfrc,
    input  wfm_pkg::timer_cmd_t   cmd,
    input  logic                  toward_white,
    input  logic                  grey_target,
    output logic [`WFM_CNT_W-1:0] cnt_next,
    output logic [1:0]            dfrc_next,
    output logic                  cnt_zero,
    output logic                  cnt_one,
    output logic                  cnt_above_settle
);
    import wfm_pkg::*;

    localparam int CNT_W = `WFM_CNT_W;
    localparam int MONO_MAX = (`WFM_FASTM_B2W_FRAMES > `WFM_FASTM_W2B_FRAMES) ?
        `WFM_FASTM_B2W_FRAMES : `WFM_FASTM_W2B_FRAMES;
    localparam int GREY_MAX = ((`WFM_W2G_FRAMES > `WFM_B2G_FRAMES) ?
        `WFM_W2G_FRAMES : `WFM_B2G_FRAMES) + `WFM_SETTLE_FRAMES;
    localparam int HOLD_MAX = (`WFM_HOLDOFF_FRAMES > MONO_MAX) ? `WFM_HOLDOFF_FRAMES : MONO_MAX;
    localparam int LOAD_MAX = (GREY_MAX > HOLD_MAX) ? GREY_MAX : HOLD_MAX;

    logic [CNT_W-1:0] mono_frames;
    logic [CNT_W-1:0] grey_frames;
    logic [1:0]       dfrc_dec;
    logic             load_cmd;

    // Drive length toward the new mono level
    assign mono_frames = toward_white ? CNT_W'(`WFM_FASTM_B2W_FRAMES) :
                                        CNT_W'(`WFM_FASTM_W2B_FRAMES);

    // Grey pulse plus the settle tail
    assign grey_frames = grey_target ? CNT_W'(`WFM_W2G_FRAMES + `WFM_SETTLE_FRAMES) :
                                       CNT_W'(`WFM_B2G_FRAMES + `WFM_SETTLE_FRAMES);

    // Cap counts down to zero and stays there
    assign dfrc_dec = (dfrc != 2'd0) ? (dfrc - 2'd1) : 2'd0;

    always_comb begin
        cnt_next  = count;
        dfrc_next = dfrc;
        case (cmd)
            TMR_DEC: begin
                cnt_next  = count - CNT_W'(1);
                dfrc_next = dfrc_dec;
            end
            TMR_LOAD_MONO: begin
                cnt_next  = mono_frames;
                dfrc_next = csr_dfrc;
            end
            // Reversal mid-drive only undoes the frames already spent
            TMR_RELOAD_MONO: begin
                cnt_next  = mono_frames - count + CNT_W'(1);
                dfrc_next = csr_dfrc;
            end
            TMR_LOAD_HOLDOFF: cnt_next = CNT_W'(`WFM_HOLDOFF_FRAMES);
            TMR_LOAD_GREY:    cnt_next = grey_frames;
            TMR_CLEAR:        cnt_next = '0;
            default:          cnt_next = count;
        endcase
    end

    // Flags on the stored count
    assign cnt_zero         = (count == '0);
    assign cnt_one          = (count == CNT_W'(1));
    assign cnt_above_settle = (count > CNT_W'(`WFM_SETTLE_FRAMES));

    // Every command that sets a new count
    assign load_cmd = cmd inside {TMR_LOAD_MONO, TMR_RELOAD_MONO,
                                  TMR_LOAD_HOLDOFF, TMR_LOAD_GREY};

    a_load_range: assert final (!load_cmd || (int'(cnt_next) <= LOAD_MAX))
        else $error("frame timer load %0d above largest frame count %0d", cnt_next, LOAD_MAX);

endmodule

/* src/pixel_stage_fsm.sv */
// Pixel stage logic, next stage and drive code for fast mono and fast grey pixels
`timescale 1ns/1ns

module pixel_stage_fsm (
    input  wfm_pkg::pixel_state_t state_in,
    input  logic [3:0]            vin,
    input  logic                  cnt_zero,
    input  logic                  cnt_one,
    input  logic                  cnt_above_settle,
    input  logic                  dfrc_zero,
    output wfm_pkg::grey_stage_t  next_stage,
    output logic [1:0]            next_prev,
    output wfm_pkg::drive_t       drive_next,
    output wfm_pkg::timer_cmd_t   tmr_cmd,
    output logic                  toward_white,
    output logic                  grey_target
);
    import wfm_pkg::*;

    logic   grey_mode;
    logic   mono_change;
    logic   hi_change;
    logic   level_change;
    logic   grey_level;
    drive_t drive_in;
    drive_t drive_hold_mono;
    drive_t drive_hold_grey;
    drive_t drive_grey_pulse;

    // Unknown modes run as fast mono
    assign grey_mode = (state_in.mode == MODE_FAST_GREY);

    // Mono compares prev bit 0, grey keeps the level in both prev bits
    assign mono_change  = (vin[3] != state_in.prev[0]);
    assign hi_change    = (vin[3] != state_in.prev[1]);
    assign level_change = (vin[3:2] != state_in.prev);

    // Only the two middle levels take a grey pulse
    assign grey_level = (vin[3:2] == 2'b10) || (vin[3:2] == 2'b01);

    assign toward_white = vin[3];
    assign grey_target  = (vin[3:2] == 2'b10);

    assign drive_in         = vin[3] ? DRIVE_WHITE : DRIVE_BLACK;
    assign drive_hold_mono  = state_in.prev[0] ? DRIVE_WHITE : DRIVE_BLACK;
    assign drive_hold_grey  = state_in.prev[1] ? DRIVE_WHITE : DRIVE_BLACK;
    // Grey pulse pushes back from the mono level
    assign drive_grey_pulse = state_in.prev[1] ? DRIVE_BLACK : DRIVE_WHITE;

    always_comb begin
        next_stage = state_in.stage;
        next_prev  = state_in.prev;
        drive_next = DRIVE_NONE;
        tmr_cmd    = TMR_HOLD;
        if (!grey_mode) begin
            // Stage field is the reserved area, kept clear
            next_stage = STAGE_DONE;
            if (cnt_zero) begin
                // Idle pixel starts a full drive on a level change
                if (mono_change) begin
                    drive_next = drive_in;
                    tmr_cmd    = TMR_LOAD_MONO;
                    next_prev  = {1'b0, vin[3]};
                end
            end else if (mono_change && dfrc_zero) begin
                // Cap expired, reverse the running drive
                drive_next = drive_in;
                tmr_cmd    = TMR_RELOAD_MONO;
                next_prev  = {1'b0, vin[3]};
            end else begin
                // Finish the running drive
                drive_next = drive_hold_mono;
                tmr_cmd    = TMR_DEC;
            end
        end else begin
            case (state_in.stage)
                STAGE_DONE: begin
                    if (level_change) begin
                        next_stage = STAGE_MONO;
                        drive_next = drive_in;
                        tmr_cmd    = TMR_LOAD_MONO;
                        next_prev  = vin[3:2];
                    end
                end
                STAGE_MONO: begin
                    if (hi_change) begin
                        drive_next = drive_in;
                        tmr_cmd    = TMR_LOAD_MONO;
                        next_prev  = vin[3:2];
                    end else begin
                        drive_next = drive_hold_grey;
                        if (cnt_one) begin
                            next_stage = STAGE_HOLD;
                            tmr_cmd    = TMR_LOAD_HOLDOFF;
                        end else begin
                            tmr_cmd = TMR_DEC;
                        end
                    end
                end
                STAGE_HOLD: begin
                    if (hi_change) begin
                        // Still cancellable, restart the mono drive
                        next_stage = STAGE_MONO;
                        drive_next = drive_in;
                        tmr_cmd    = TMR_LOAD_MONO;
                        next_prev  = vin[3:2];
                    end else if (cnt_zero) begin
                        next_stage = grey_level ? STAGE_GREY : STAGE_DONE;
                        tmr_cmd    = grey_level ? TMR_LOAD_GREY : TMR_CLEAR;
                        next_prev  = vin[3:2];
                    end else begin
                        tmr_cmd = TMR_DEC;
                    end
                end
                default: begin
                    // Grey pulse runs to the end, input ignored
                    drive_next = cnt_above_settle ? drive_grey_pulse : DRIVE_NONE;
                    if (cnt_zero) begin
                        next_stage = STAGE_DONE;
                        tmr_cmd    = TMR_CLEAR;
                    end else begin
                        tmr_cmd = TMR_DEC;
                    end
                end
            endcase
        end
    end

    // Stored mono words keep the reserved stage area clear
    a_mono_stage: assert final (grey_mode || (state_in.stage == STAGE_DONE))
        else $error("fast mono pixel stored with stage %0d", state_in.stage);

endmodule

/* src/state_writeback.sv */
// State writeback, applies set-mode and init overrides and registers the pixel result
`timescale 1ns/1ns

module state_writeback (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pix_valid,
    input  wfm_pkg::pixel_state_t next_state,
    input  wfm_pkg::drive_t       drive_next,
    input  logic                  set_mode_apply,
    input  wfm_pkg::op_t          op,
    output logic                  out_valid,
    output wfm_pkg::pixel_state_t state_out,
    output wfm_pkg::drive_t       drive
);
    import wfm_pkg::*;

    // Initial words of the two modes
    localparam pixel_state_t MONO_INIT = '{mode: MODE_FAST_MONO, stage: STAGE_DONE,
                                           count: '0, dfrc: 2'd0, prev: 2'd1};
    localparam pixel_state_t GREY_INIT = '{mode: MODE_FAST_GREY, stage: STAGE_DONE,
                                           count: '0, dfrc: 2'd0, prev: 2'd3};

    pixel_state_t state_wb;
    drive_t       drive_wb;

    always_comb begin
        state_wb = next_state;
        drive_wb = drive_next;
        // Invalid parameter falls back to mono
        if (set_mode_apply) begin
            state_wb = (op.param == SET_FAST_GREY) ? GREY_INIT : MONO_INIT;
        end
        // Init cycles the panel through black and white, counter runs down
        // x111xxx idle, 1xxxxxx black, 0xxxxxx white
        if (op.init) begin
            state_wb = MONO_INIT;
            if (op.framecnt[5:3] == 3'b111) begin
                drive_wb = DRIVE_NONE;
            end else if (op.framecnt[6]) begin
                drive_wb = DRIVE_BLACK;
            end else begin
                drive_wb = DRIVE_WHITE;
            end
        end
    end

    // One cycle latency, result held between pixels
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            state_out <= '0;
            drive     <= DRIVE_NONE;
        end else begin
            out_valid <= pix_valid;
            if (pix_valid) begin
                state_out <= state_wb;
                drive     <= drive_wb;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

endmodule

/* src/pixel_processor.sv */
// Pixel processor top, per-pixel waveform engine with one cycle of latency
`timescale 1ns/1ns
`include "wfm_settings.svh"

module pixel_processor (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pix_valid,
    input  logic [3:0]            pix_in,
    input  wfm_pkg::pixel_state_t state_in,
    input  wfm_pkg::op_t          op,
    input  logic [1:0]            csr_dfrc,
    output logic                  out_valid,
    output wfm_pkg::pixel_state_t state_out,
    output wfm_pkg::drive_t       drive
);
    import wfm_pkg::*;

    logic [3:0]            vin;
    logic                  set_mode_apply;
    grey_stage_t           next_stage;
    logic [1:0]            next_prev;
    drive_t                drive_next;
    timer_cmd_t            tmr_cmd;
    logic                  toward_white;
    logic                  grey_target;
    logic [`WFM_CNT_W-1:0] cnt_next;
    logic [1:0]            dfrc_next;
    logic                  cnt_zero;
    logic                  cnt_one;
    logic                  cnt_above_settle;
    logic                  dfrc_zero;
    pixel_state_t          next_state;

    // Clear flag is folded into vin already
    pixel_source_select u_src (
        .pix_in(pix_in), .op(op), .vin(vin),
        .force_clear(), .set_mode_apply(set_mode_apply)
    );

    assign dfrc_zero = (state_in.dfrc == 2'd0);

    pixel_stage_fsm u_fsm (
        .state_in(state_in), .vin(vin), .cnt_zero(cnt_zero), .cnt_one(cnt_one),
        .cnt_above_settle(cnt_above_settle), .dfrc_zero(dfrc_zero),
        .next_stage(next_stage), .next_prev(next_prev), .drive_next(drive_next),
        .tmr_cmd(tmr_cmd), .toward_white(toward_white), .grey_target(grey_target)
    );

    frame_timer u_tmr (
        .count(state_in.count), .dfrc(state_in.dfrc), .csr_dfrc(csr_dfrc),
        .cmd(tmr_cmd), .toward_white(toward_white), .grey_target(grey_target),
        .cnt_next(cnt_next), .dfrc_next(dfrc_next), .cnt_zero(cnt_zero),
        .cnt_one(cnt_one), .cnt_above_settle(cnt_above_settle)
    );

    // Mode nibble passes through, the rest comes from the stage logic and timer
    assign next_state = '{mode: state_in.mode, stage: next_stage, count: cnt_next,
                          dfrc: dfrc_next, prev: next_prev};

    state_writeback u_wb (
        .clk(clk), .rst_n(rst_n), .pix_valid(pix_valid), .next_state(next_state),
        .drive_next(drive_next), .set_mode_apply(set_mode_apply), .op(op),
        .out_valid(out_valid), .state_out(state_out), .drive(drive)
    );

endmodule

/* verif/tb_clock_gen.sv */
// Testbench clock and reset generator, 100 ns clock with reset held low for 10 cycles
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release just after the last reset edge, like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #5 rst_n = 1'b1;
    end

endmodule

/* verif/tb_pixel_processor.sv */
// Pixel processor testbench, random pixels against a reference model with one cycle latency
`timescale 1ns/1ns
`include "wfm_settings.svh"

module tb_pixel_processor;
    import wfm_pkg::*;

    localparam int NUM_CYCLES    = 640;
    localparam int STREAM_CYCLES = 40;

    // Expected result of one accepted pixel
    typedef struct packed {
        pixel_state_t state;
        drive_t       drive;
    } expect_t;

    logic         clk;
    logic         rst_n;
    logic         pix_valid;
    logic [3:0]   pix_in;
    pixel_state_t state_in;
    op_t          op;
    logic [1:0]   csr_dfrc;
    logic         out_valid;
    pixel_state_t state_out;
    drive_t       drive;

    logic [31:0]  lfsr = 32'h453c3a0a;
    int           cyc = 0;
    int           errors = 0;
    int           checked = 0;
    expect_t      exp_q[$];
    int           cyc_q[$];

    tb_clock_gen clk_gen (.clk(clk), .rst_n(rst_n));

    pixel_processor uut (
        .clk(clk), .rst_n(rst_n), .pix_valid(pix_valid), .pix_in(pix_in),
        .state_in(state_in), .op(op), .csr_dfrc(csr_dfrc),
        .out_valid(out_valid), .state_out(state_out), .drive(drive)
    );

    // Edge count, the acceptance stamp for each pixel
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // Expected next state and drive for one pixel
    function automatic expect_t ref_pixel(input logic [3:0] pix, input pixel_state_t s,
                                          input op_t o, input logic [1:0] cap);
        expect_t      r;
        pixel_state_t n;
        pixel_state_t mono_init;
        pixel_state_t grey_init;
        drive_t       d;
        drive_t       to_input;
        logic [3:0]   v;
        logic         first_frame;
        logic         clear;
        logic [5:0]   mono_len;
        logic [5:0]   grey_len;
        mono_init   = '{mode: MODE_FAST_MONO, stage: STAGE_DONE, count: 6'd0,
                        dfrc: 2'd0, prev: 2'd1};
        grey_init   = '{mode: MODE_FAST_GREY, stage: STAGE_DONE, count: 6'd0,
                        dfrc: 2'd0, prev: 2'd3};
        first_frame = (o.framecnt == 7'd0);
        clear       = o.valid && ((o.cmd == OP_REDRAW) || ((o.cmd == OP_SETMODE) && !first_frame));
        // Clear colour from the global counter
        v = pix;
        if (clear) begin
            v = ((o.framecnt[4] && o.framecnt[3]) || o.framecnt[5]) ? 4'h0 : 4'hF;
        end
        to_input = v[3] ? DRIVE_WHITE : DRIVE_BLACK;
        mono_len = v[3] ? `WFM_FASTM_B2W_FRAMES : `WFM_FASTM_W2B_FRAMES;
        grey_len = (v[3:2] == 2'b10) ? (`WFM_W2G_FRAMES + `WFM_SETTLE_FRAMES) :
                                       (`WFM_B2G_FRAMES + `WFM_SETTLE_FRAMES);
        n = s;
        d = DRIVE_NONE;
        if (s.mode != MODE_FAST_GREY) begin
            n.stage = STAGE_DONE;
            if ((v[3] != s.prev[0]) && ((s.count == 0) || (s.dfrc == 0))) begin
                // New drive from idle, or reversal once the cap has run out
                d       = to_input;
                n.count = (s.count == 0) ? mono_len : 6'(mono_len - s.count + 1);
                n.dfrc  = cap;
                n.prev  = {1'b0, v[3]};
            end else if (s.count != 0) begin
                d       = s.prev[0] ? DRIVE_WHITE : DRIVE_BLACK;
                n.count = s.count - 6'd1;
                n.dfrc  = (s.dfrc == 0) ? 2'd0 : s.dfrc - 2'd1;
            end
        end else if ((s.stage == STAGE_GREY) || (s.stage == STAGE_DONE && v[3:2] == s.prev)) begin
            // Grey pulse ignores the input, settled DONE pixel holds
            if (s.stage == STAGE_GREY) begin
                d       = (s.count > `WFM_SETTLE_FRAMES) ? (s.prev[1] ? DRIVE_BLACK : DRIVE_WHITE)
                                                         : DRIVE_NONE;
                n.stage = (s.count == 0) ? STAGE_DONE : STAGE_GREY;
                n.count = (s.count == 0) ? 6'd0 : s.count - 6'd1;
                n.dfrc  = (s.count == 0) ? s.dfrc : ((s.dfrc == 0) ? 2'd0 : s.dfrc - 2'd1);
            end
        end else if ((s.stage == STAGE_DONE) || (v[3] != s.prev[1])) begin
            // Level change restarts the mono part of the grey sequence
            n.stage = STAGE_MONO;
            d       = to_input;
            n.count = mono_len;
            n.dfrc  = cap;
            n.prev  = v[3:2];
        end else if (s.stage == STAGE_MONO) begin
            d = s.prev[1] ? DRIVE_WHITE : DRIVE_BLACK;
            if (s.count == 1) begin
                n.stage = STAGE_HOLD;
                n.count = `WFM_HOLDOFF_FRAMES;
            end else begin
                n.count = s.count - 6'd1;
                n.dfrc  = (s.dfrc == 0) ? 2'd0 : s.dfrc - 2'd1;
            end
        end else if (s.count == 0) begin
            // End of hold, only the middle levels take a grey pulse
            n.prev = v[3:2];
            if ((v[3:2] == 2'b10) || (v[3:2] == 2'b01)) begin
                n.stage = STAGE_GREY;
                n.count = grey_len;
            end else begin
                n.stage = STAGE_DONE;
            end
        end else begin
            n.count = s.count - 6'd1;
            n.dfrc  = (s.dfrc == 0) ? 2'd0 : s.dfrc - 2'd1;
        end
        // Overrides, init last
        if (o.valid && (o.cmd == OP_SETMODE) && first_frame) begin
            n = (o.param == SET_FAST_GREY) ? grey_init : mono_init;
        end
        if (o.init) begin
            n = mono_init;
            if (o.framecnt[5:3] == 3'b111) begin
                d = DRIVE_NONE;
            end else begin
                d = o.framecnt[6] ? DRIVE_BLACK : DRIVE_WHITE;
            end
        end
        r.state = n;
        r.drive = d;
        return r;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Random pixel, state, operation and cap, queued with its expectation
    task automatic apply_random_pixel(input logic stream);
        pixel_state_t st;
        op_t          o;
        logic [2:0]   opsel;
        st.mode    = rand_bits(1) ? MODE_FAST_GREY : MODE_FAST_MONO;
        st.stage   = grey_stage_t'(rand_bits(2));
        st.count   = 6'(rand_bits(4));
        st.dfrc    = 2'(rand_bits(2));
        st.prev    = 2'(rand_bits(2));
        // Mono words have a clear stage area and never count past a mono drive
        if (st.mode == MODE_FAST_MONO) begin
            st.stage = STAGE_DONE;
            st.count = st.count % 6'(`WFM_FASTM_W2B_FRAMES + 1);
        end
        opsel      = 3'(rand_bits(3));
        o.valid    = 1'b1;
        o.cmd      = OP_NONE;
        o.param    = setmode_t'(rand_bits(2));
        o.framecnt = 7'(rand_bits(7));
        o.init     = 1'b0;
        case (opsel)
            3'd4: o.cmd = OP_REDRAW;
            3'd5: begin
                o.cmd      = OP_SETMODE;
                o.framecnt = '0;
            end
            3'd6: o.cmd = OP_SETMODE;
            3'd7: o.init = 1'b1;
            default: begin
                o.valid = rand_bits(1);
                o.cmd   = (rand_bits(2) == 0) ? OP_REDRAW : OP_NONE;
            end
        endcase
        pix_valid = stream || (rand_bits(2) != 0);
        pix_in    = 4'(rand_bits(4));
        state_in  = st;
        op        = o;
        csr_dfrc  = 2'(rand_bits(2));
        if (pix_valid) begin
            exp_q.push_back(ref_pixel(pix_in, st, o, csr_dfrc));
            cyc_q.push_back(cyc + 1);
        end
    endtask

    task automatic report_and_finish();
        $display("Pixels checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // Outputs sampled mid-cycle, each must match the pixel from the edge before
    always @(negedge clk) begin : compare_outputs
        expect_t e;
        int      c;
        if (rst_n) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Output at cycle %0d without an accepted pixel", cyc);
                end else begin
                    e = exp_q.pop_front();
                    c = cyc_q.pop_front();
                    checked++;
                    check_value(cyc, c, "output cycle");
                    check_value(state_out, e.state, "state_out");
                    check_value(drive, e.drive, "drive");
                end
            end else if ((cyc_q.size() != 0) && (cyc_q[0] == cyc)) begin
                errors++;
                $display("Pixel accepted at cycle %0d produced no output", cyc);
                e = exp_q.pop_front();
                c = cyc_q.pop_front();
            end
        end
    end

    initial begin : run_test
        int waited;
        pix_valid = 1'b0;
        pix_in    = '0;
        state_in  = '0;
        op        = '0;
        csr_dfrc  = '0;
        waited    = 0;
        while ((rst_n !== 1'b1) && (waited < 40)) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("Timeout: reset was never released");
        end else begin
            // Quiet outputs straight after reset
            @(negedge clk);
            check_value(out_valid, 1'b0, "out_valid after reset");
            check_value(drive, DRIVE_NONE, "drive after reset");
            check_value(state_out, '0, "state_out after reset");
            // Back-to-back stream first, then random gaps
            for (int i = 0; i < NUM_CYCLES; i++) begin
                @(posedge clk);
                #5;
                apply_random_pixel(i < STREAM_CYCLES);
            end
            @(posedge clk);
            #5;
            pix_valid = 1'b0;
            waited = 0;
            while ((exp_q.size() != 0) && (waited < 10)) begin
                @(negedge clk);
                waited++;
            end
            if (exp_q.size() != 0) begin
                errors++;
                $display("Timeout: %0d accepted pixels never produced an output", exp_q.size());
            end
        end
        report_and_finish();
    end

endmodule

/* compile.f */
+incdir+src
src/wfm_pkg.sv
src/pixel_source_select.sv
src/frame_timer.sv
src/pixel_stage_fsm.sv
src/state_writeback.sv
src/pixel_processor.sv
verif/tb_clock_gen.sv
verif/tb_pixel_processor.sv
